/* rtl/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Datapath width and register count
`define RV_XLEN      32
`define RV_REG_COUNT 32

// Operation buffer and retire buffer depths
`define RV_OP_DEPTH  4
`define RV_RET_DEPTH 4

`endif

/* rtl/rv_core_pkg.sv */
`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;

    // Only the integer opcodes survive
    typedef enum logic [6:0] {
        OPC_REG = 7'b0110011,
        OPC_IMM = 7'b0010011,
        OPC_LUI = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_AND  = 4'b0110,
        ALU_SLL  = 4'b0111,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_e;

    // Fully resolved operation, operands already read
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        reg_addr_t rd;
        logic      wr_en;   // Writes rd on execute
        logic      illegal;
    } issue_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     result;
        logic      illegal;
    } retire_t;

endpackage

/* rtl/rf_read_if.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

// Two combinational read ports of the register file
interface rf_read_if;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    modport reader (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    modport regfile (input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);
endinterface

/* rtl/reg_file.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    rf_read_if.regfile rd_port,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data
);

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin  // x0 never written
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads are combinational, x0 reads as zero
    assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
    assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

endmodule

/* rtl/decode_issue.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module decode_issue import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        instr_ready,
    rf_read_if.reader   rf,
    input  logic        wb_en,
    input  reg_addr_t   wb_rd,
    output logic        issue_valid,
    output issue_t      issue_data,
    input  logic        issue_ready
);

    logic [`RV_REG_COUNT-1:0] pending;  // One bit per register with a write in flight

    opcode_e    opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic       bit30;
    word_t      imm_i;
    word_t      imm_u;
    alu_op_e    f3_op;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_imm;
    logic       writes;
    logic       illegal;
    logic       hazard;
    logic       issue_fire;

    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign bit30  = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    // funct3 to ALU op, shared by R-type and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  f3_op = (bit30 && (opcode == OPC_REG)) ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = bit30 ? ALU_SRA : ALU_SRL;  // SRAI shares bit 30
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        writes  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OPC_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                writes  = 1'b1;
            end
            OPC_IMM: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            OPC_LUI: begin
                use_imm = 1'b1;   // 0 + imm
                writes  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // Stall on any pending source the format reads, or on pending rd
    assign hazard = (use_rs1 && pending[rs1]) ||
                    (use_rs2 && pending[rs2]) ||
                    (writes && pending[rd]);

    assign issue_valid = instr_valid && !hazard;
    assign instr_ready = issue_ready && !hazard;
    assign issue_fire  = issue_valid && issue_ready;

    assign issue_data = '{
        alu_op:  (opcode == OPC_LUI) ? ALU_ADD : f3_op,
        op_a:    use_rs1 ? rf.rs1_data : '0,
        op_b:    use_imm ? ((opcode == OPC_LUI) ? imm_u : imm_i) : rf.rs2_data,
        rd:      rd,
        wr_en:   writes,
        illegal: illegal
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wb_en)
                pending[wb_rd] <= 1'b0;
            // Set after clear, issue never targets a pending rd anyway
            if (issue_fire && writes && (rd != '0))
                pending[rd] <= 1'b1;
        end
    end

endmodule

/* rtl/op_fifo.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module op_fifo import rv_core_pkg::*; #(
    parameter type T     = word_t,
    parameter int  DEPTH = `RV_OP_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    // Handshake flags come from count alone
    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or simultaneous push and pop
            endcase
        end
    end

endmodule

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu import rv_core_pkg::*; (
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_e alu_op,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];  // Low five bits only

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_SLT:  result = word_t'($signed(operand_a) < $signed(operand_b));
            ALU_SLTU: result = word_t'(operand_a < operand_b);
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_OR:   result = operand_a | operand_b;
            ALU_AND:  result = operand_a & operand_b;
            ALU_SLL:  result = operand_a << shamt;
            ALU_SRL:  result = operand_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  result = word_t'($signed(operand_a) >>> shamt);
            default:  result = '0;
        endcase
    end

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit import rv_core_pkg::*; (
    input  logic      op_valid,
    output logic      op_ready,
    input  issue_t    op_data,
    output logic      ret_valid,
    input  logic      ret_ready,
    output retire_t   ret_data,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    word_t alu_result;
    logic  fire;

    alu u_alu (
        .operand_a (op_data.op_a),
        .operand_b (op_data.op_b),
        .alu_op    (op_data.alu_op),
        .result    (alu_result)
    );

    // Pop only when the retire buffer has room
    assign op_ready  = ret_ready;
    assign ret_valid = op_valid;
    assign fire      = op_valid && ret_ready;

    // Register write in the same edge as the retire push
    assign wb_en   = fire && op_data.wr_en;
    assign wb_rd   = op_data.rd;
    assign wb_data = alu_result;

    // Illegal ops retire with rd and result zeroed
    assign ret_data = '{
        rd:      op_data.illegal ? '0 : op_data.rd,
        result:  op_data.illegal ? '0 : alu_result,
        illegal: op_data.illegal
    };

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Instruction stream
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        instr_ready,
    // Retire stream
    output logic        ret_valid,
    output reg_addr_t   ret_rd,
    output word_t       ret_result,
    output logic        ret_illegal,
    input  logic        ret_ready
);

    logic      issue_valid;
    logic      issue_ready;
    issue_t    issue_data;
    logic      op_valid;
    logic      op_ready;
    issue_t    op_data;
    logic      exe_ret_valid;
    logic      exe_ret_ready;
    retire_t   exe_ret_data;
    retire_t   ret_data;   // Head of the retire buffer
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    rf_read_if rf_rd ();

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_port (rf_rd),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    decode_issue u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .rf          (rf_rd),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready)
    );

    // Issued operations
    op_fifo #(.T(issue_t), .DEPTH(`RV_OP_DEPTH)) u_op_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (issue_data),
        .out_valid (op_valid),
        .out_ready (op_ready),
        .out_data  (op_data)
    );

    execute_unit u_execute (
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_data   (op_data),
        .ret_valid (exe_ret_valid),
        .ret_ready (exe_ret_ready),
        .ret_data  (exe_ret_data),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // Retire records, in issue order
    op_fifo #(.T(retire_t), .DEPTH(`RV_RET_DEPTH)) u_ret_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (exe_ret_valid),
        .in_ready  (exe_ret_ready),
        .in_data   (exe_ret_data),
        .out_valid (ret_valid),
        .out_ready (ret_ready),
        .out_data  (ret_data)
    );

    assign ret_rd      = ret_data.rd;
    assign ret_result  = ret_data.result;
    assign ret_illegal = ret_data.illegal;

endmodule

/* tests/rv_core_chk.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core_chk import rv_core_pkg::*; (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     instr_valid,
    input logic [31:0]              instr,
    input logic                     instr_ready,
    input logic                     ret_valid,
    input logic                     ret_ready,
    input reg_addr_t                ret_rd,
    input word_t                    ret_result,
    input logic                     ret_illegal,
    input logic [`RV_REG_COUNT-1:0] pending
);

    logic reads_rs1;
    logic reads_rs2;
    logic src_pending;

    assign reads_rs1   = (instr[6:0] == OPC_REG) || (instr[6:0] == OPC_IMM);
    assign reads_rs2   = (instr[6:0] == OPC_REG);
    assign src_pending = (reads_rs1 && pending[instr[19:15]]) ||
                         (reads_rs2 && pending[instr[24:20]]);

    // Retire head holds until the consumer takes it
    ret_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && !ret_ready |=> ret_valid && $stable({ret_rd, ret_result, ret_illegal}))
        else $error("retire output changed before it was accepted");

    src_stall: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && src_pending |-> !instr_ready)
        else $error("instr_ready high with a pending source register");

    illegal_rd: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && ret_illegal |-> ret_rd == '0)
        else $error("illegal retire record carries a nonzero destination");

endmodule

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps
`include "rv_core_cfg.svh"

module rv_core_tb import rv_core_pkg::*; ();

    localparam int PERIOD  = 100;
    // Instructions per test, sizes the watchdog
    localparam int N_RTYPE = 3 * 14;
    localparam int N_OPIMM = 3 * 12;
    localparam int N_CHAIN = 2 + 8 * 3;
    localparam int N_X0    = 5;
    localparam int N_BP    = 16;
    localparam int N_ILL   = 6;
    localparam int N_TOTAL = N_RTYPE + N_OPIMM + N_CHAIN + N_X0 + N_BP + N_ILL;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        ret_valid;
    reg_addr_t   ret_rd;
    word_t       ret_result;
    logic        ret_illegal;
    logic        ret_ready;

    word_t       model [`RV_REG_COUNT];  // Reference register state
    retire_t     exp_q [$];              // Records still owed by the DUT
    logic [15:0] lfsr;
    string       test_name;
    int          error_count;
    int          check_count;
    int          retired;

    rv_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .ret_valid   (ret_valid),
        .ret_rd      (ret_rd),
        .ret_result  (ret_result),
        .ret_illegal (ret_illegal),
        .ret_ready   (ret_ready)
    );

    bind rv_core rv_core_chk chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .ret_valid   (ret_valid),
        .ret_ready   (ret_ready),
        .ret_rd      (ret_rd),
        .ret_result  (ret_result),
        .ret_illegal (ret_illegal),
        .pending     (u_decode.pending)
    );

    always #(PERIOD/2) clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // RV32I integer semantics by funct3, alt selects SUB or SRA
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display(
                "Fail %s: expected rd=%0d result=%h illegal=%b, actual rd=%0d result=%h illegal=%b",
                name, exp.rd, exp.result, exp.illegal, act.rd, act.result, act.illegal);
        end
    endtask

    // Drive on the falling edge, return right after the accepting rising edge
    task automatic send_instr(input logic [31:0] word, input retire_t exp);
        exp_q.push_back(exp);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        #(PERIOD/4);
        while (!instr_ready) begin
            @(posedge clk);
            #(PERIOD/4);
        end
        @(posedge clk);
    endtask

    task automatic idle_input();
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;  // Opcode zero reads no register
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                          input reg_addr_t rs1, input reg_addr_t rs2);
        word_t r;
        r = alu_model(f3, alt, model[rs1], model[rs2]);
        if (rd != '0)
            model[rd] = r;
        send_instr({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_REG}, retire_t'{rd, r, 1'b0});
    endtask

    task automatic imm_op(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                          input logic [11:0] imm);
        word_t r;
        r = alu_model(f3, (f3 == 3'b101) && imm[10], model[rs1], {{20{imm[11]}}, imm});
        if (rd != '0)
            model[rd] = r;
        send_instr({imm, rs1, f3, rd, OPC_IMM}, retire_t'{rd, r, 1'b0});
    endtask

    task automatic lui_op(input reg_addr_t rd, input logic [19:0] imm);
        if (rd != '0)
            model[rd] = {imm, 12'b0};
        send_instr({imm, rd, OPC_LUI}, retire_t'{rd, {imm, 12'b0}, 1'b0});
    endtask

    task automatic bad_op(input logic [31:0] word);
        send_instr(word, retire_t'{5'd0, 32'd0, 1'b1});
    endtask

    // LUI plus ADDI, upper part rounded for the sign of the low twelve bits
    task automatic load_reg(input reg_addr_t rd, input word_t value);
        lui_op(rd, value[31:12] + 20'(value[11]));
        imm_op(3'b000, rd, rd, value[11:0]);
    endtask

    task automatic wait_retired();
        int waited;
        waited = 0;
        idle_input();
        while (exp_q.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("Missing retire records in %s: %0d never arrived", test_name, exp_q.size());
            exp_q.delete();
        end
    endtask

    // Retire monitor, samples a quarter period before each rising edge
    initial begin
        retire_t act;
        forever begin
            @(negedge clk);
            #(PERIOD/4);
            if (rst_n && ret_valid && ret_ready) begin
                act = retire_t'{ret_rd, ret_result, ret_illegal};
                retired++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected retire record in %s, no instruction left to match",
                             test_name);
                end else begin
                    check_retire(test_name, exp_q.pop_front(), act);
                end
            end
        end
    end

    task automatic r_type_sweep();
        word_t a;
        test_name = "r_type_sweep";
        for (int round = 0; round < 3; round++) begin
            a = rand_bits(32);
            if (round == 0)
                a[31] = 1'b1;  // Negative source for SRA and SLT
            load_reg(5'd1, a);
            load_reg(5'd2, rand_bits(32));
            reg_op(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
            reg_op(3'b000, 1'b1, 5'd4, 5'd1, 5'd2);
            for (int f = 1; f < 8; f++) begin
                reg_op(3'(f), 1'b0, reg_addr_t'(4 + f), 5'd1, 5'd2);
            end
            reg_op(3'b101, 1'b1, 5'd12, 5'd1, 5'd2);
        end
        wait_retired();
    endtask

    task automatic op_imm_sweep();
        word_t      a;
        logic [4:0] shamt;
        test_name = "op_imm_sweep";
        for (int round = 0; round < 3; round++) begin
            a = rand_bits(32);
            if (round == 0)
                a[31] = 1'b1;
            load_reg(5'd1, a);
            for (int f = 0; f < 8; f++) begin
                if (f != 1 && f != 5)
                    imm_op(3'(f), reg_addr_t'(13 + f), 5'd1, 12'(rand_bits(12)));
            end
            shamt = 5'(rand_bits(5));
            imm_op(3'b001, 5'd23, 5'd1, {7'b0, shamt});
            imm_op(3'b101, 5'd24, 5'd1, {7'b0, shamt});
            imm_op(3'b101, 5'd25, 5'd1, {7'b0100000, shamt});  // SRAI
            lui_op(5'd26, 20'(rand_bits(20)));
        end
        wait_retired();
    endtask

    task automatic dependent_chains();
        test_name = "dependent_chains";
        load_reg(5'd4, rand_bits(32));
        for (int i = 0; i < 8; i++) begin
            imm_op(3'b000, 5'd4, 5'd4, 12'(rand_bits(12)));
            reg_op(3'b000, 1'b1, 5'd5, 5'd4, 5'd5);
            reg_op(3'b100, 1'b0, 5'd4, 5'd5, 5'd4);  // Rewrites x4 behind the ADDI
        end
        wait_retired();
    endtask

    task automatic x0_writes();
        test_name = "x0_writes";
        imm_op(3'b000, 5'd0, 5'd1, 12'(rand_bits(12)));
        lui_op(5'd0, 20'(rand_bits(20)));
        reg_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
        reg_op(3'b000, 1'b0, 5'd8, 5'd0, 5'd0);
        imm_op(3'b011, 5'd9, 5'd0, 12'd1);
        wait_retired();
    endtask

    task automatic retire_backpressure();
        int   sent;
        int   start;
        logic dropped;
        test_name = "retire_backpressure";
        sent      = 0;
        dropped   = 1'b0;
        start     = retired;
        @(negedge clk);
        ret_ready = 1'b0;
        while (!dropped && sent < N_BP) begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr       = '0;
            #(PERIOD/4);
            if (!instr_ready) begin
                dropped = 1'b1;
            end else begin
                lui_op(reg_addr_t'(10 + sent), 20'(rand_bits(20)));
                sent++;
            end
        end
        repeat (20) @(negedge clk);
        // Both buffers fill completely before the stall
        check_word(test_name, word_t'(`RV_OP_DEPTH + `RV_RET_DEPTH), word_t'(sent));
        if (!dropped) begin
            error_count++;
            $display("instr_ready never dropped while ret_ready was held low");
        end
        ret_ready = 1'b1;
        wait_retired();
        check_word(test_name, word_t'(sent), word_t'(retired - start));
    endtask

    task automatic illegal_opcode();
        test_name = "illegal_opcode";
        load_reg(5'd3, rand_bits(32));
        bad_op({12'h123, 5'd3, 3'b010, 5'd3, 7'b0000011});  // LW x3
        bad_op({20'h00010, 5'd3, 7'b1101111});              // JAL x3
        bad_op(32'h0000_0073);
        reg_op(3'b000, 1'b0, 5'd4, 5'd3, 5'd0);             // x3 must be unchanged
        wait_retired();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        ret_ready   = 1'b1;
        lfsr        = 16'd25;
        error_count = 0;
        check_count = 0;
        retired     = 0;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        r_type_sweep();
        op_imm_sweep();
        dependent_chains();
        x0_writes();
        retire_backpressure();
        illegal_opcode();

        $display("Checks: %0d, errors: %0d, records retired: %0d",
                 check_count, error_count, retired);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Twenty cycles per instruction is far beyond any stall
    initial begin
        #(N_TOTAL * 20 * PERIOD);
        $display("Timeout after %0d cycles, the DUT stopped making progress", N_TOTAL * 20);
        $display("test failed");
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rf_read_if.sv
rtl/reg_file.sv
rtl/decode_issue.sv
rtl/op_fifo.sv
rtl/alu.sv
rtl/execute_unit.sv
rtl/rv_core.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f rv_core.f --top-module rv_core_tb -o Vrv_core_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vrv_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0
